/* source/pass_pkg.sv */
package pass_pkg;

    typedef logic        [7:0]  pixel_t;     // unsigned ifmap pixel
    typedef logic signed [7:0]  weight_t;    // signed kernel tap
    typedef logic signed [19:0] psum_t;      // room for KERNEL taps of 8x9 bit products
    typedef logic        [5:0]  row_idx_t;

    // pass sequence, order follows the controller walk
    typedef enum logic [2:0] {
        PASS_IDLE,
        INIT_WEIGHT,
        FIFO_PRELOAD,
        PREHEAT,
        NORMAL_LOOP,
        PASS_DONE
    } pass_phase_t;

    // bit 0 grants GLB reads, bit 1 lets partial sums out
    typedef enum logic [1:0] {
        ARB_OFF    = 2'b00,
        ARB_READ   = 2'b01,
        ARB_WRITE  = 2'b10,
        ARB_NORMAL = 2'b11
    } arb_mode_t;

    typedef struct packed {
        pixel_t pixel;
        logic   last_in_row;    // set on the final pixel of a GLB row
    } fifo_beat_t;

    typedef struct packed {
        row_idx_t   row;
        logic [5:0] col;        // window start column
        psum_t      sum;
    } psum_beat_t;

endpackage

/* source/pass_controller.sv */
`timescale 1ns/1ps

module pass_controller import pass_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pass_start,
    input  row_idx_t    num_rows,
    input  logic        weight_done,
    input  logic        fifo_full,
    input  logic        preheat_done,
    input  logic        row_done,
    output logic        weight_load_state,
    output logic        fifo_preload_state,
    output logic        preheat_state,
    output logic        normal_loop_state,
    output arb_mode_t   arb_mode,
    output pass_phase_t phase,
    output logic        pass_done
);

    pass_phase_t state;
    pass_phase_t state_nxt;
    row_idx_t    rows_total;     // num_rows as seen at start
    row_idx_t    rows_done;
    logic        last_row;

    assign last_row = (row_idx_t'(rows_done + 1'b1) == rows_total);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PASS_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rows_total <= '0;
            rows_done  <= '0;
        end else if (state == PASS_IDLE && pass_start) begin
            rows_total <= num_rows;
            rows_done  <= '0;
        end else if (row_done) begin
            rows_done <= rows_done + 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            PASS_IDLE:    if (pass_start)   state_nxt = INIT_WEIGHT;
            INIT_WEIGHT:  if (weight_done)  state_nxt = FIFO_PRELOAD;
            FIFO_PRELOAD: if (fifo_full)    state_nxt = PREHEAT;
            PREHEAT:      if (preheat_done) state_nxt = NORMAL_LOOP;
            NORMAL_LOOP: begin
                if (row_done) begin
                    state_nxt = last_row ? PASS_DONE : FIFO_PRELOAD;
                end
            end
            PASS_DONE:    state_nxt = PASS_IDLE;    // single cycle
            default:      state_nxt = PASS_IDLE;
        endcase
    end

    // GLB arbiter grant per phase
    always_comb begin
        case (state)
            FIFO_PRELOAD: arb_mode = ARB_READ;
            PREHEAT:      arb_mode = ARB_READ;
            NORMAL_LOOP:  arb_mode = ARB_NORMAL;
            default:      arb_mode = ARB_OFF;    // idle, weight load, done
        endcase
    end

    assign weight_load_state  = (state == INIT_WEIGHT);
    assign fifo_preload_state = (state == FIFO_PRELOAD);
    assign preheat_state      = (state == PREHEAT);
    assign normal_loop_state  = (state == NORMAL_LOOP);
    assign pass_done          = (state == PASS_DONE);
    assign phase              = state;

    // the conv unit must close a row only inside the loop
    row_done_in_loop: assert property (
        @(posedge clk) disable iff (!rst_n) row_done |-> normal_loop_state
    ) else $error("row_done outside NORMAL_LOOP");

endmodule

/* source/glb_reader.sv */
`timescale 1ns/1ps

module glb_reader import pass_pkg::*; #(
    parameter int ROW_LEN  = 16,
    parameter int MAX_ROWS = 8
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  glb_wr_en,
    input  logic [$clog2(MAX_ROWS*ROW_LEN)-1:0]   glb_wr_addr,
    input  pixel_t                                glb_wr_data,
    input  arb_mode_t                             arb_mode,
    input  logic                                  fifo_full,
    output logic                                  push,
    output fifo_beat_t                            push_beat
);

    localparam int GLB_SIZE = MAX_ROWS * ROW_LEN;
    localparam int AW       = $clog2(GLB_SIZE);
    localparam int CW       = $clog2(ROW_LEN);

    pixel_t        glb_mem [GLB_SIZE];    // row-major pixel store
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] rd_col;
    logic          row_hold;              // row finished, wait for its loop to close
    logic          arb_wr_q;
    logic          row_end;
    logic          rd_grant;

    assign row_end  = (rd_col == CW'(ROW_LEN - 1));
    // one read in flight at a time so full never lags a push
    assign rd_grant = arb_mode[0] && !fifo_full && !push && !row_hold;

    always_ff @(posedge clk) begin
        if (glb_wr_en) begin
            glb_mem[glb_wr_addr] <= glb_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_grant) begin
            push_beat.pixel       <= glb_mem[rd_ptr];
            push_beat.last_in_row <= row_end;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            rd_col   <= '0;
            row_hold <= 1'b0;
            push     <= 1'b0;
            arb_wr_q <= 1'b0;
        end else begin
            push     <= rd_grant;
            arb_wr_q <= arb_mode[1];
            if (arb_mode == ARB_OFF) begin
                rd_ptr   <= '0;    // every pass starts at row 0
                rd_col   <= '0;
                row_hold <= 1'b0;
            end else if (rd_grant) begin
                rd_ptr   <= (rd_ptr == AW'(GLB_SIZE - 1)) ? '0 : rd_ptr + 1'b1;
                rd_col   <= row_end ? '0 : rd_col + 1'b1;
                row_hold <= row_end;
            end else if (arb_wr_q && !arb_mode[1]) begin
                row_hold <= 1'b0;  // loop closed, next row preload
            end
        end
    end

    host_write_when_off: assert property (
        @(posedge clk) disable iff (!rst_n) glb_wr_en |-> (arb_mode == ARB_OFF)
    ) else $error("host GLB write while arbiter is active");

endmodule

/* source/ifmap_fifo.sv */
`timescale 1ns/1ps

module ifmap_fifo import pass_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       push,
    input  fifo_beat_t push_beat,
    input  logic       pop,
    output fifo_beat_t pop_beat,
    output logic       full,
    output logic       empty
);

    localparam int PW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    fifo_beat_t    mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;

    assign full     = (count == CW'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign pop_beat = mem[rd_ptr];    // head is readable in the pop cycle

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

    // reader and conv unit must honour the flags
    no_push_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) push |-> !full
    ) else $error("ifmap FIFO overflow");

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) pop |-> !empty
    ) else $error("ifmap FIFO underflow");

endmodule

/* source/row_conv.sv */
`timescale 1ns/1ps

// KERNEL of 2 or more, the window keeps KERNEL-1 past pixels
module row_conv import pass_pkg::*; #(
    parameter int KERNEL = 3
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       weight_load_state,
    input  logic       preheat_state,
    input  logic       normal_loop_state,
    input  arb_mode_t  arb_mode,
    input  logic       weight_valid,
    input  weight_t    weight_data,
    input  logic       fifo_empty,
    output logic       pop,
    input  fifo_beat_t pop_beat,
    output logic       weight_done,
    output logic       preheat_done,
    output logic       row_done,
    output logic       psum_valid,
    output psum_beat_t psum_out
);

    typedef enum logic [1:0] {
        CV_CAPTURE,
        CV_HOLD,
        CV_PREHEAT,
        CV_RUN
    } conv_state_t;

    localparam int CW = $clog2(KERNEL + 1);

    conv_state_t   cv_state;
    weight_t       weights [KERNEL];
    pixel_t        win     [KERNEL-1];    // win[0] is the oldest pixel
    pixel_t        taps    [KERNEL];
    logic [CW-1:0] wt_cnt;
    logic [CW-1:0] pre_cnt;
    row_idx_t      row_cnt;
    logic [5:0]    col_cnt;
    logic          wt_take;
    logic          pre_pop;
    logic          run_pop;
    psum_t         dot;

    assign wt_take      = (cv_state == CV_CAPTURE) && weight_load_state && weight_valid;
    assign pre_pop      = (cv_state == CV_PREHEAT) && !fifo_empty;
    assign run_pop      = (cv_state == CV_RUN) && normal_loop_state && arb_mode[1] && !fifo_empty;
    assign pop          = pre_pop || run_pop;
    assign weight_done  = wt_take && (wt_cnt == CW'(KERNEL - 1));
    assign preheat_done = pre_pop && (pre_cnt == CW'(KERNEL - 2));

    // full window: stored history plus the pixel being popped
    always_comb begin
        for (int k = 0; k < KERNEL - 1; k++) begin
            taps[k] = win[k];
        end
        taps[KERNEL-1] = pop_beat.pixel;
    end

    always_comb begin
        logic signed [16:0] prod;
        dot = '0;
        for (int k = 0; k < KERNEL; k++) begin
            prod = weights[k] * $signed({1'b0, taps[k]});
            dot  = dot + psum_t'(prod);
        end
    end

    always_ff @(posedge clk) begin
        if (wt_take) begin
            weights[wt_cnt] <= weight_data;    // k-th strobe is tap k
        end
        if (pop) begin
            for (int k = 0; k < KERNEL - 1; k++) begin
                win[k] <= taps[k+1];
            end
        end
        if (run_pop) begin
            psum_out.row <= row_cnt;
            psum_out.col <= col_cnt;
            psum_out.sum <= dot;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cv_state   <= CV_CAPTURE;
            wt_cnt     <= '0;
            pre_cnt    <= '0;
            row_cnt    <= '0;
            col_cnt    <= '0;
            row_done   <= 1'b0;
            psum_valid <= 1'b0;
        end else begin
            row_done   <= 1'b0;
            psum_valid <= run_pop;
            case (cv_state)
                CV_CAPTURE: begin
                    if (weight_done) begin
                        wt_cnt   <= '0;
                        cv_state <= CV_HOLD;
                    end else if (wt_take) begin
                        wt_cnt <= wt_cnt + 1'b1;
                    end
                end
                CV_HOLD: begin
                    if (arb_mode == ARB_OFF) begin
                        row_cnt  <= '0;          // pass over, rearm for weights
                        cv_state <= CV_CAPTURE;
                    end else if (preheat_state) begin
                        cv_state <= CV_PREHEAT;
                    end
                end
                CV_PREHEAT: begin
                    if (preheat_done) begin
                        pre_cnt  <= '0;
                        cv_state <= CV_RUN;
                    end else if (pre_pop) begin
                        pre_cnt <= pre_cnt + 1'b1;
                    end
                end
                CV_RUN: begin
                    if (run_pop) begin
                        col_cnt <= col_cnt + 1'b1;
                        if (pop_beat.last_in_row) begin
                            col_cnt  <= '0;
                            row_cnt  <= row_cnt + 1'b1;
                            row_done <= 1'b1;    // lands with the last psum
                            cv_state <= CV_HOLD;
                        end
                    end
                end
                default: cv_state <= CV_CAPTURE;
            endcase
        end
    end

endmodule

/* source/pass_engine.sv */
`timescale 1ns/1ps

// needs FIFO_DEPTH <= ROW_LEN and KERNEL <= FIFO_DEPTH
module pass_engine import pass_pkg::*; #(
    parameter int ROW_LEN    = 16,
    parameter int KERNEL     = 3,
    parameter int MAX_ROWS   = 8,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                glb_wr_en,
    input  logic [$clog2(MAX_ROWS*ROW_LEN)-1:0] glb_wr_addr,
    input  pixel_t                              glb_wr_data,
    input  logic                                pass_start,
    input  row_idx_t                            num_rows,
    output logic                                pass_done,
    input  logic                                weight_valid,
    input  weight_t                             weight_data,
    output logic                                psum_valid,
    output psum_beat_t                          psum_out,
    output pass_phase_t                         phase
);

    logic       weight_load_state;
    logic       preheat_state;
    logic       normal_loop_state;
    arb_mode_t  arb_mode;
    logic       fifo_full;
    logic       fifo_empty;
    logic       weight_done;
    logic       preheat_done;
    logic       row_done;
    logic       push;
    logic       pop;
    fifo_beat_t push_beat;
    fifo_beat_t pop_beat;

    pass_controller ctrl_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .pass_start         (pass_start),
        .num_rows           (num_rows),
        .weight_done        (weight_done),
        .fifo_full          (fifo_full),
        .preheat_done       (preheat_done),
        .row_done           (row_done),
        .weight_load_state  (weight_load_state),
        .fifo_preload_state (),                   // preload shows on phase
        .preheat_state      (preheat_state),
        .normal_loop_state  (normal_loop_state),
        .arb_mode           (arb_mode),
        .phase              (phase),
        .pass_done          (pass_done)
    );

    glb_reader #(.ROW_LEN(ROW_LEN), .MAX_ROWS(MAX_ROWS)) reader_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .glb_wr_en   (glb_wr_en),
        .glb_wr_addr (glb_wr_addr),
        .glb_wr_data (glb_wr_data),
        .arb_mode    (arb_mode),
        .fifo_full   (fifo_full),
        .push        (push),
        .push_beat   (push_beat)
    );

    ifmap_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_beat (push_beat),
        .pop       (pop),
        .pop_beat  (pop_beat),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    row_conv #(.KERNEL(KERNEL)) conv_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .weight_load_state (weight_load_state),
        .preheat_state     (preheat_state),
        .normal_loop_state (normal_loop_state),
        .arb_mode          (arb_mode),
        .weight_valid      (weight_valid),
        .weight_data       (weight_data),
        .fifo_empty        (fifo_empty),
        .pop               (pop),
        .pop_beat          (pop_beat),
        .weight_done       (weight_done),
        .preheat_done      (preheat_done),
        .row_done          (row_done),
        .psum_valid        (psum_valid),
        .psum_out          (psum_out)
    );

endmodule

/* tests/pass_engine_tb.sv */
`timescale 1ns/1ps

module pass_engine_tb
    import pass_pkg::*;
();

    localparam int ROW_LEN     = 16;
    localparam int KERNEL      = 3;
    localparam int MAX_ROWS    = 8;
    localparam int FIFO_DEPTH  = 8;
    localparam int ADDR_W      = $clog2(MAX_ROWS * ROW_LEN);
    localparam int OUT_PER_ROW = ROW_LEN - KERNEL + 1;
    localparam int WEIGHT_BASE = 2;     // word offsets in the trace
    localparam int PIXEL_BASE  = 8;
    localparam int PSUM_BASE   = 40;

    logic              clk;
    logic              rst_n;
    logic              glb_wr_en;
    logic [ADDR_W-1:0] glb_wr_addr;
    pixel_t            glb_wr_data;
    logic              pass_start;
    row_idx_t          num_rows;
    logic              pass_done;
    logic              weight_valid;
    weight_t           weight_data;
    logic              psum_valid;
    psum_beat_t        psum_out;
    pass_phase_t       phase;

    logic [31:0] trace_mem [128];
    logic [7:0]  lfsr_state;
    int          strobes_given;     // weight strobes of the current pass
    int          psum_count;
    int          pass_done_count;
    int          preload_count;     // entries into FIFO_PRELOAD
    pass_phase_t prev_phase;
    int          wd_cycles;

    pass_engine #(
        .ROW_LEN    (ROW_LEN),
        .KERNEL     (KERNEL),
        .MAX_ROWS   (MAX_ROWS),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) pass_engine_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .glb_wr_en    (glb_wr_en),
        .glb_wr_addr  (glb_wr_addr),
        .glb_wr_data  (glb_wr_data),
        .pass_start   (pass_start),
        .num_rows     (num_rows),
        .pass_done    (pass_done),
        .weight_valid (weight_valid),
        .weight_data  (weight_data),
        .psum_valid   (psum_valid),
        .psum_out     (psum_out),
        .phase        (phase)
    );

    always #4 clk = ~clk;

    // galois form, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        lfsr_next = {1'b0, s[7:1]} ^ (s[0] ? 8'hB8 : 8'h00);
    endfunction

    task automatic take_gap(output int gap);
        gap = 0;
        repeat (2) begin
            gap        = (gap << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic glb_write(input int addr, input pixel_t data);
        @(posedge clk);
        #1;
        glb_wr_en   = 1'b1;
        glb_wr_addr = ADDR_W'(addr);
        glb_wr_data = data;
    endtask

    task automatic run_pass(input int rows, input int pass_idx);
        int psum_base;
        int done_base;
        int preload_base;
        int gap;
        psum_base     = psum_count;
        done_base     = pass_done_count;
        preload_base  = preload_count;
        strobes_given = 0;
        @(posedge clk);
        #1;
        num_rows   = row_idx_t'(rows);
        pass_start = 1'b1;
        @(posedge clk);
        #1;
        pass_start = 1'b0;
        for (int k = 0; k < KERNEL; k++) begin
            take_gap(gap);
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            weight_valid  = 1'b1;
            weight_data   = trace_mem[WEIGHT_BASE + pass_idx * KERNEL + k][7:0];
            strobes_given = strobes_given + 1;
            @(posedge clk);
            #1;
            weight_valid = 1'b0;
        end
        while (!pass_done) @(negedge clk);
        @(negedge clk);
        check_value("phase", 32'(phase), 32'(PASS_IDLE));
        repeat (4) @(negedge clk);
        check_value("pass_done pulses", pass_done_count - done_base, 1);
        check_value("psum_valid beats", psum_count - psum_base, rows * OUT_PER_ROW);
        check_value("FIFO_PRELOAD entries", preload_count - preload_base, rows);
        check_value("phase", 32'(phase), 32'(PASS_IDLE));
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin : monitor
        logic [31:0] exp_beat;
        if (!rst_n) begin
            psum_count      = 0;
            pass_done_count = 0;
            preload_count   = 0;
            prev_phase      = PASS_IDLE;
        end else begin
            if (psum_valid) begin
                exp_beat = trace_mem[PSUM_BASE + psum_count];
                check_value("phase", 32'(phase), 32'(NORMAL_LOOP));
                check_value("psum_out.row", {26'd0, psum_out.row}, {26'd0, exp_beat[31:26]});
                check_value("psum_out.col", {26'd0, psum_out.col}, {26'd0, exp_beat[25:20]});
                check_value("psum_out.sum", {12'd0, psum_out.sum}, {12'd0, exp_beat[19:0]});
                psum_count = psum_count + 1;
            end
            if (prev_phase == INIT_WEIGHT && phase != INIT_WEIGHT) begin
                check_value("weight_valid strobes", strobes_given, KERNEL);
                check_value("phase", 32'(phase), 32'(FIFO_PRELOAD));
            end
            if (phase == FIFO_PRELOAD && prev_phase != FIFO_PRELOAD) begin
                preload_count = preload_count + 1;
            end
            if (pass_done) begin
                pass_done_count = pass_done_count + 1;
            end
            prev_phase = phase;
        end
    end

    initial begin : watchdog
        @(posedge rst_n);
        wd_cycles = int'(trace_mem[0] + trace_mem[1]) * ROW_LEN * 8 + 400;
        repeat (wd_cycles) @(posedge clk);
        $display("TIMEOUT: passes did not complete within %0d clock cycles", wd_cycles);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        glb_wr_en     = 1'b0;
        glb_wr_addr   = '0;
        glb_wr_data   = '0;
        pass_start    = 1'b0;
        num_rows      = '0;
        weight_valid  = 1'b0;
        weight_data   = '0;
        strobes_given = 0;
        lfsr_state    = 8'd82;
        $readmemh("tests/pass_trace.hex", trace_mem);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("phase", 32'(phase), 32'(PASS_IDLE));
        check_value("pass_done", {31'd0, pass_done}, 32'd0);
        check_value("psum_valid", {31'd0, psum_valid}, 32'd0);
        for (int a = 0; a < int'(trace_mem[0]) * ROW_LEN; a++) begin
            glb_write(a, trace_mem[PIXEL_BASE + a][7:0]);
        end
        @(posedge clk);
        #1;
        glb_wr_en = 1'b0;
        run_pass(int'(trace_mem[0]), 0);
        run_pass(int'(trace_mem[1]), 1);    // reuses GLB row 0, new weights
        $display("All tests passed");
        $finish;
    end

endmodule

/* tests/pass_trace.hex */
// words 0-1: row counts of pass 1 and 2; words 2-7: weights of pass 1 then pass 2
// @08 GLB pixels by address; @28 and @44 expected beats {row[5:0], col[5:0], sum[19:0]}
@00
00000002 00000001
00000001 000000FE 00000003
000000FF 00000002 000000FC
@08
00000003 0000000B 00000013 0000001B 00000023 0000002B 00000033 0000003B
00000043 0000004B 00000053 0000005B 00000063 0000006B 00000073 0000007B
00000083 0000008B 00000093 0000009B 000000A3 000000AB 000000B3 000000BB
000000C3 000000CB 000000D3 000000DB 000000E3 000000EB 000000F3 000000FB
@28
00000026 00100036 00200046 00300056 00400066 00500076 00600086
00700096 008000A6 009000B6 00A000C6 00B000D6 00C000E6 00D000F6
04000126 04100136 04200146 04300156 04400166 04500176 04600186
04700196 048001A6 049001B6 04A001C6 04B001D6 04C001E6 04D001F6
@44
000FFFC7 001FFFAF 002FFF97 003FFF7F 004FFF67 005FFF4F 006FFF37
007FFF1F 008FFF07 009FFEEF 00AFFED7 00BFFEBF 00CFFEA7 00DFFE8F

/* pass_engine.f */
source/pass_pkg.sv
source/pass_controller.sv
source/glb_reader.sv
source/ifmap_fifo.sv
source/row_conv.sv
source/pass_engine.sv
tests/pass_engine_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the pass engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module pass_engine_tb -f pass_engine.f -o pass_engine_sim \
    && ./obj_dir/pass_engine_sim \
    || { echo "simulation failed"; exit 1; }
